/* Makefile */
VERILATOR ?= verilator
TOP       ?= conv_core_tb
FLIST     ?= conv_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/conv_core_tb.sv */
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_core_tb;
  import conv_pkg::*;

  localparam int     MAX_IN  = 3;
  localparam int     TAPS    = `FIL_SIZE * `FIL_SIZE;
  localparam int     TIMEOUT = 200;
  // Cycles for the last partial sum to pass the multiply-add and the write port.
  localparam int     DRAIN   = `D_CONV + 3;
  localparam longint DMAX    = (longint'(1) << (`DWIDTH - 1)) - 1;
  localparam int     NTESTS  = 7;

  typedef struct packed {
    int size;
    int images;
    int limit;
    int max_gap;
    int fea;
  } test_row_t;

  // Image size, image count, pixel and weight magnitude limit, longest gap
  // between pixels, expected feature map side.
  test_row_t tests [NTESTS] = '{
    '{6, 1, 7, 0, 4},
    '{8, 3, 15, 0, 6},
    '{6, 1, 32767, 0, 4},
    '{9, 2, 100, 3, 7},
    '{4, 1, 50, 1, 2},
    '{7, 2, 50, 0, 5},
    '{12, 1, 50, 2, 10}
  };
  string names [NTESTS] = '{"single_image", "three_images", "saturation", "random_gaps",
                            "size_4", "size_7", "size_12"};

  logic        clk;
  logic        xrst;
  core_state_t core_state;
  size_t       img_size;
  logic        first_input;
  logic        last_input;
  logic        in_start;
  logic        in_valid;
  data_t       in_data;
  logic        weight_we;
  logic [3:0]  weight_addr;
  data_t       weight_data;
  logic        out_start;
  logic        out_valid;
  logic        out_stop;
  data_t       out_data;
  size_t       fea_size;

  logic [31:0] lfsr;
  data_t       pix [MAX_IN][`MAX_IMG][`MAX_IMG];
  data_t       wgt [MAX_IN][TAPS];
  data_t       expect_fea [`MAX_IMG * `MAX_IMG];

  tb_clock u_tb_clock (
    .clk  (clk),
    .xrst (xrst)
  );

  conv_core u_conv_core (
    .clk         (clk),
    .xrst        (xrst),
    .core_state  (core_state),
    .img_size    (img_size),
    .first_input (first_input),
    .last_input  (last_input),
    .in_start    (in_start),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .out_start   (out_start),
    .out_valid   (out_valid),
    .out_stop    (out_stop),
    .out_data    (out_data),
    .fea_size    (fea_size)
  );

  // Taps at bits 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic data_t draw_value(input int limit);
    int mag;
    mag = draw_bits(16) % (limit + 1);
    if (draw_bits(1) == 1) begin
      mag = -mag;
    end
    return data_t'(mag);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_feature(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_size(input string name, input size_t exp, input size_t act);
    if (act !== exp) begin
      report_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // Each feature is the sum over images and taps, then ReLU and clipping.
  task automatic build_model(input int n_img, input int fea);
    longint acc;
    for (int fy = 0; fy < fea; fy++) begin
      for (int fx = 0; fx < fea; fx++) begin
        acc = 0;
        for (int i = 0; i < n_img; i++) begin
          for (int r = 0; r < `FIL_SIZE; r++) begin
            for (int c = 0; c < `FIL_SIZE; c++) begin
              acc += longint'(wgt[i][r*`FIL_SIZE+c]) * longint'(pix[i][fy+r][fx+c]);
            end
          end
        end
        if (acc < 0) begin
          expect_fea[fy*fea+fx] = '0;
        end else if (acc > DMAX) begin
          expect_fea[fy*fea+fx] = data_t'(DMAX);
        end else begin
          expect_fea[fy*fea+fx] = data_t'(acc);
        end
      end
    end
  endtask

  task automatic check_idle_after_reset();
    int cycles;
    cycles = 0;
    while (!xrst) begin
      if (cycles == TIMEOUT) begin
        report_failure("reset was never released");
      end
      cycles++;
      @(negedge clk);
    end
    check_size("reset fea_size", size_t'(0), fea_size);
    repeat (4) begin
      @(negedge clk);
      if (out_start !== 1'b0 || out_valid !== 1'b0 || out_stop !== 1'b0) begin
        report_failure("an output strobe went high right after reset");
      end
    end
  endtask

  task automatic write_weights(input int img);
    for (int k = 0; k < TAPS; k++) begin
      @(posedge clk);
      weight_we   <= 1'b1;
      weight_addr <= 4'(k);
      weight_data <= wgt[img][k];
    end
    @(posedge clk);
    weight_we <= 1'b0;
  endtask

  task automatic stream_image(input int img, input test_row_t row);
    int gap;
    @(posedge clk);
    core_state  <= CORE_INPUT;
    img_size    <= size_t'(row.size);
    first_input <= (img == 0);
    last_input  <= (img == row.images - 1);
    in_start    <= 1'b1;
    for (int y = 0; y < row.size; y++) begin
      for (int x = 0; x < row.size; x++) begin
        gap = (row.max_gap > 0) ? draw_bits(2) % (row.max_gap + 1) : 0;
        @(posedge clk);
        in_start <= 1'b0;
        in_valid <= 1'b1;
        in_data  <= pix[img][y][x];
        repeat (gap) begin
          @(posedge clk);
          in_valid <= 1'b0;
        end
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    repeat (DRAIN) @(posedge clk);
    core_state <= CORE_WAIT;
  endtask

  task automatic wait_for_start(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_start) begin
      if (cycles == TIMEOUT) begin
        report_failure($sformatf("%s: out_start did not arrive in %0d cycles", name, TIMEOUT));
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic wait_for_valid(input string name, input int count);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!out_valid) begin
      if (cycles == TIMEOUT) begin
        report_failure($sformatf("%s: out_valid for feature %0d never came", name, count));
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic read_features(input string name, input int fea);
    int last;
    last = fea * fea - 1;
    @(posedge clk);
    core_state <= CORE_OUTPUT;
    wait_for_start(name);
    for (int count = 0; count <= last; count++) begin
      if (count > 0) begin
        wait_for_valid(name, count);
      end
      if (out_valid !== 1'b1 || out_start !== (count == 0)) begin
        report_failure($sformatf("%s: out_start or out_valid wrong at feature %0d",
                                 name, count));
      end
      if (out_stop !== (count == last)) begin
        report_failure($sformatf("%s: out_stop wrong at feature %0d", name, count));
      end
      check_feature($sformatf("%s feature (%0d,%0d)", name, count % fea, count / fea),
                    expect_fea[count], out_data);
    end
    repeat (DRAIN) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        report_failure($sformatf("%s: more features than fea_size squared", name));
      end
    end
    @(posedge clk);
    core_state <= CORE_WAIT;
  endtask

  task automatic run_test(input int t);
    test_row_t row;
    row = tests[t];
    for (int i = 0; i < row.images; i++) begin
      for (int k = 0; k < TAPS; k++) begin
        wgt[i][k] = draw_value(row.limit);
      end
      for (int y = 0; y < row.size; y++) begin
        for (int x = 0; x < row.size; x++) begin
          pix[i][y][x] = draw_value(row.limit);
        end
      end
    end
    build_model(row.images, row.fea);
    for (int i = 0; i < row.images; i++) begin
      write_weights(i);
      stream_image(i, row);
      @(negedge clk);
      check_size({names[t], " fea_size"}, size_t'(row.fea), fea_size);
    end
    read_features(names[t], row.fea);
  endtask

  initial begin
    core_state  = CORE_WAIT;
    img_size    = '0;
    first_input = 1'b0;
    last_input  = 1'b0;
    in_start    = 1'b0;
    in_valid    = 1'b0;
    in_data     = '0;
    weight_we   = 1'b0;
    weight_addr = '0;
    weight_data = '0;
    lfsr        = 32'h0804f1d5;
    check_idle_after_reset();
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Reset is held low for the first eight rising edges.
  initial begin
    xrst = 1'b0;
    repeat (8) @(posedge clk);
    xrst <= 1'b1;
  end

endmodule

/* conv_core.f */
+incdir+hdl
hdl/conv_pkg.sv
hdl/conv_ctrl.sv
hdl/conv_window.sv
hdl/feat_mem.sv
hdl/conv_out.sv
hdl/conv_core.sv
bench/tb_clock.sv
bench/conv_core_tb.sv

/* hdl/conv_core.sv */
`timescale 1ns/1ns

module conv_core (
  input  logic                  clk,
  input  logic                  xrst,
  input  conv_pkg::core_state_t core_state,
  input  conv_pkg::size_t       img_size,
  input  logic                  first_input,
  input  logic                  last_input,
  input  logic                  in_start,
  input  logic                  in_valid,
  input  conv_pkg::data_t       in_data,
  input  logic                  weight_we,
  input  logic [3:0]            weight_addr,
  input  conv_pkg::data_t       weight_data,
  output logic                  out_start,
  output logic                  out_valid,
  output logic                  out_stop,
  output conv_pkg::data_t       out_data,
  output conv_pkg::size_t       fea_size
);
  import conv_pkg::*;

  logic       feat_we;
  logic       feat_rst;
  feat_addr_t feat_addr;
  feat_addr_t feat_addr_d1;
  logic       conv_oe;
  accum_t     conv_sum;
  accum_t     rdata;

  // The window strobes stay inside the controller, which uses them to
  // pace the feature memory.
  conv_ctrl u_conv_ctrl (
    .clk          (clk),
    .xrst         (xrst),
    .core_state   (core_state),
    .img_size     (img_size),
    .first_input  (first_input),
    .last_input   (last_input),
    .in_start     (in_start),
    .in_valid     (in_valid),
    .conv_valid   (),
    .conv_stop    (),
    .feat_we      (feat_we),
    .feat_rst     (feat_rst),
    .feat_addr    (feat_addr),
    .feat_addr_d1 (feat_addr_d1),
    .conv_oe      (conv_oe),
    .out_start    (out_start),
    .out_valid    (out_valid),
    .out_stop     (out_stop),
    .fea_size     (fea_size)
  );

  conv_window u_conv_window (
    .clk         (clk),
    .xrst        (xrst),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .img_size    (img_size),
    .weight_we   (weight_we),
    .weight_addr (weight_addr),
    .weight_data (weight_data),
    .conv_sum    (conv_sum)
  );

  feat_mem u_feat_mem (
    .clk     (clk),
    .xrst    (xrst),
    .we      (feat_we),
    .rst     (feat_rst),
    .addr    (feat_addr),
    .addr_d1 (feat_addr_d1),
    .wdata   (conv_sum),
    .rdata   (rdata)
  );

  conv_out u_conv_out (
    .clk      (clk),
    .xrst     (xrst),
    .oe       (conv_oe),
    .rdata    (rdata),
    .out_data (out_data)
  );

endmodule

/* hdl/conv_ctrl.sv */
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_ctrl (
  input  logic                  clk,
  input  logic                  xrst,
  input  conv_pkg::core_state_t core_state,
  input  conv_pkg::size_t       img_size,
  input  logic                  first_input,
  input  logic                  last_input,
  input  logic                  in_start,
  input  logic                  in_valid,
  output logic                  conv_valid,
  output logic                  conv_stop,
  output logic                  feat_we,
  output logic                  feat_rst,
  output conv_pkg::feat_addr_t  feat_addr,
  output conv_pkg::feat_addr_t  feat_addr_d1,
  output logic                  conv_oe,
  output logic                  out_start,
  output logic                  out_valid,
  output logic                  out_stop,
  output conv_pkg::size_t       fea_size
);
  import conv_pkg::*;

  localparam int    D_OUT = `D_CONV + `D_ACCUM;
  localparam size_t K_M1  = size_t'(`FIL_SIZE - 1);
  localparam size_t ONE   = size_t'(1);

  typedef enum logic {S_IDLE, S_ACTIVE} state_t;

  state_t             r_state;
  size_t              r_img_size;
  size_t              r_fea_size;
  size_t              r_x;
  size_t              r_y;
  logic               r_first_input;
  logic               r_ready;
  logic               r_wait_back;
  logic [`D_CONV-1:0] r_we;
  logic [`D_CONV-1:0] r_rst;
  feat_addr_t         r_addr [`D_CONV+2];
  logic [D_OUT:0]     r_ostart;
  logic [D_OUT:0]     r_ovalid;
  logic [D_OUT:0]     r_ostop;
  logic               go;
  logic               in_step;
  logic               in_last;
  logic               scan;
  logic               scan_last;
  size_t              cur_size;

  // A start pulse may arrive together with the first pixel, so the
  // incoming size is used directly in that cycle.
  assign go        = (r_state == S_IDLE) && in_start;
  assign cur_size  = go ? img_size : r_img_size;
  assign in_step   = (r_state == S_ACTIVE || go) && core_state == CORE_INPUT && in_valid;
  assign in_last   = (r_x == cur_size - ONE) && (r_y == cur_size - ONE);
  assign scan      = (r_state == S_ACTIVE) && core_state == CORE_OUTPUT
                     && r_ready && !r_wait_back;
  assign scan_last = (r_x == r_fea_size - ONE) && (r_y == r_fea_size - ONE);

  assign fea_size  = r_fea_size;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_state <= S_IDLE;
    end else if (go) begin
      r_state <= S_ACTIVE;
    end else if (r_state == S_ACTIVE && out_stop) begin
      r_state <= S_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_img_size <= '0;
      r_fea_size <= '0;
    end else if (go) begin
      r_img_size <= img_size;
      r_fea_size <= img_size - K_M1;
    end
  end

  // Row-major scan over the image while pixels come in, and over the
  // feature map while results go out.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_x <= '0;
      r_y <= '0;
    end else if (in_step) begin
      if (r_x == cur_size - ONE) begin
        r_x <= '0;
        r_y <= (r_y == cur_size - ONE) ? '0 : r_y + ONE;
      end else begin
        r_x <= r_x + ONE;
      end
    end else if (scan) begin
      if (r_x == r_fea_size - ONE) begin
        r_x <= '0;
        r_y <= (r_y == r_fea_size - ONE) ? '0 : r_y + ONE;
      end else begin
        r_x <= r_x + ONE;
      end
    end else if (r_state == S_IDLE) begin
      r_x <= '0;
      r_y <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_first_input <= 1'b0;
      r_ready       <= 1'b0;
      r_wait_back   <= 1'b0;
    end else begin
      r_first_input <= first_input;
      if (go) begin
        r_ready <= 1'b0;
      end else if (in_step && in_last && last_input) begin
        r_ready <= 1'b1;
      end
      // Hold off further scanning until the next image set begins.
      if (go) begin
        r_wait_back <= 1'b0;
      end else if (scan && scan_last) begin
        r_wait_back <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      conv_valid <= 1'b0;
      conv_stop  <= 1'b0;
    end else begin
      conv_valid <= in_step && (r_x >= K_M1) && (r_y >= K_M1);
      conv_stop  <= in_step && in_last;
    end
  end

  // Write strobes wait for the partial sum to leave the multiply-add.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_we  <= '0;
      r_rst <= '0;
    end else begin
      r_we[0]  <= conv_valid;
      r_rst[0] <= conv_valid && r_first_input;
      for (int i = 1; i < `D_CONV; i++) begin
        r_we[i]  <= r_we[i-1];
        r_rst[i] <= r_rst[i-1];
      end
    end
  end

  assign feat_we  = r_we[`D_CONV-1];
  assign feat_rst = r_rst[`D_CONV-1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `D_CONV + 2; i++) begin
        r_addr[i] <= '0;
      end
    end else begin
      if (conv_stop || r_wait_back) begin
        r_addr[0] <= '0;
      end else if (conv_valid || scan) begin
        r_addr[0] <= r_addr[0] + feat_addr_t'(1);
      end
      for (int i = 1; i < `D_CONV + 2; i++) begin
        r_addr[i] <= r_addr[i-1];
      end
    end
  end

  assign feat_addr    = r_addr[`D_CONV];
  assign feat_addr_d1 = r_addr[`D_CONV+1];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_ostart <= '0;
      r_ovalid <= '0;
      r_ostop  <= '0;
    end else begin
      r_ostart[0] <= scan && (r_x == '0) && (r_y == '0);
      r_ovalid[0] <= scan;
      r_ostop[0]  <= scan && scan_last;
      for (int i = 1; i <= D_OUT; i++) begin
        r_ostart[i] <= r_ostart[i-1];
        r_ovalid[i] <= r_ovalid[i-1];
        r_ostop[i]  <= r_ostop[i-1];
      end
    end
  end

  assign conv_oe   = r_ovalid[D_OUT-1];
  assign out_start = r_ostart[D_OUT];
  assign out_valid = r_ovalid[D_OUT];
  assign out_stop  = r_ostop[D_OUT];

endmodule

/* hdl/conv_defines.svh */
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// Pixel and weight width, and the width of the feature accumulator.
`define DWIDTH   16
`define AWIDTH   40

// Image size and coordinate width, and the feature memory address width.
`define LWIDTH   6
`define FACCUM   10

// Kernel side and the longest row a line buffer can hold.
`define FIL_SIZE 3
`define MAX_IMG  32

// Multiply-add depth and output stage depth.
`define D_CONV   2
`define D_ACCUM  1

`endif

/* hdl/conv_out.sv */
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_out (
  input  logic             clk,
  input  logic             xrst,
  input  logic             oe,
  input  conv_pkg::accum_t rdata,
  output conv_pkg::data_t  out_data
);
  import conv_pkg::*;

  localparam accum_t DATA_MAX = accum_t'((1 << (`DWIDTH - 1)) - 1);

  data_t clamped;

  // Negative sums become zero and larger ones clip to the largest pixel value.
  always_comb begin
    if (rdata < accum_t'(0)) begin
      clamped = '0;
    end else if (rdata > DATA_MAX) begin
      clamped = DATA_MAX[`DWIDTH-1:0];
    end else begin
      clamped = rdata[`DWIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_data <= '0;
    end else if (oe) begin
      out_data <= clamped;
    end
  end

endmodule

/* hdl/conv_pkg.sv */
`include "conv_defines.svh"

package conv_pkg;

  typedef logic signed [`DWIDTH-1:0] data_t;
  typedef logic signed [`AWIDTH-1:0] accum_t;
  typedef logic [`LWIDTH-1:0]        size_t;
  typedef logic [`FACCUM-1:0]        feat_addr_t;

  // The outside sequencer drives the phase of the core.
  typedef enum logic [1:0] {
    CORE_WAIT    = 2'd0,
    CORE_NETWORK = 2'd1,
    CORE_INPUT   = 2'd2,
    CORE_OUTPUT  = 2'd3
  } core_state_t;

endpackage

/* hdl/conv_window.sv */
`timescale 1ns/1ns
`include "conv_defines.svh"

module conv_window (
  input  logic            clk,
  input  logic            xrst,
  input  logic            in_valid,
  input  conv_pkg::data_t in_data,
  input  conv_pkg::size_t img_size,
  input  logic            weight_we,
  input  logic [3:0]      weight_addr,
  input  conv_pkg::data_t weight_data,
  output conv_pkg::accum_t conv_sum
);
  import conv_pkg::*;

  localparam int K     = `FIL_SIZE;
  localparam int TAPS  = K * K;
  localparam int LB_AW = $clog2(`MAX_IMG);

  data_t            weight   [TAPS];
  data_t            line_buf [K-1][`MAX_IMG];
  data_t            win      [K][K];
  data_t            col_in   [K];
  accum_t           prod     [TAPS];
  accum_t           prod_sum;
  size_t            col;
  logic [LB_AW-1:0] lb_idx;

  // Taps are stored row-major with the top-left tap at address 0.
  always_ff @(posedge clk) begin
    if (weight_we) begin
      weight[weight_addr] <= weight_data;
    end
  end

  assign lb_idx = col[LB_AW-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      col <= '0;
    end else if (in_valid) begin
      if (col == img_size - size_t'(1)) begin
        col <= '0;
      end else begin
        col <= col + size_t'(1);
      end
    end
  end

  // The new column takes its older rows from the line buffers and its
  // bottom row straight from the input.
  always_comb begin
    for (int r = 0; r < K - 1; r++) begin
      col_in[r] = line_buf[r][lb_idx];
    end
    col_in[K-1] = in_data;
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int r = 0; r < K - 1; r++) begin
        line_buf[r][lb_idx] <= col_in[r+1];
      end
      for (int r = 0; r < K; r++) begin
        for (int c = 0; c < K - 1; c++) begin
          win[r][c] <= win[r][c+1];
        end
        win[r][K-1] <= col_in[r];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K; c++) begin
        prod[r*K+c] <= accum_t'(win[r][c]) * accum_t'(weight[r*K+c]);
      end
    end
  end

  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < TAPS; i++) begin
      prod_sum = prod_sum + prod[i];
    end
  end

  // The second stage yields a fresh partial sum every cycle.
  always_ff @(posedge clk) begin
    conv_sum <= prod_sum;
  end

endmodule

/* hdl/feat_mem.sv */
`timescale 1ns/1ns
`include "conv_defines.svh"

module feat_mem (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 we,
  input  logic                 rst,
  input  conv_pkg::feat_addr_t addr,
  input  conv_pkg::feat_addr_t addr_d1,
  input  conv_pkg::accum_t     wdata,
  output conv_pkg::accum_t     rdata
);
  import conv_pkg::*;

  localparam int DEPTH = 1 << `FACCUM;

  accum_t mem [DEPTH];
  accum_t wdata_d;
  logic   we_d;
  logic   rst_d;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      we_d  <= 1'b0;
      rst_d <= 1'b0;
    end else begin
      we_d  <= we;
      rst_d <= rst;
    end
  end

  always_ff @(posedge clk) begin
    rdata   <= mem[addr];
    wdata_d <= wdata;
  end

  // The first image overwrites, later images add to the stored sum.
  always_ff @(posedge clk) begin
    if (we_d) begin
      mem[addr_d1] <= rst_d ? wdata_d : rdata + wdata_d;
    end
  end

endmodule
